// File: Bender.yml
package:
  name: cpu_core

sources:
  # packages first
  - files:
      - design/isa_pkg.sv
      - design/core_pkg.sv
  - files:
      - design/fetch_stage.sv
      - design/hazard_unit.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/reg_file.sv
      - design/cpu_core.sv
  - target: test
    files:
      - verif/tb_cpu_core.sv

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int DATA_W = 32;
	localparam int HALF_W = 16;
	localparam int REG_N  = 8;
	localparam int REG_AW = 3;
	localparam int PC_W   = 15; // word address

	// register write enables per half word
	// bit 0 low half, bit 1 high half
	typedef logic [1:0] wmask_t;

	localparam wmask_t MASK_LO  = 2'b01;
	localparam wmask_t MASK_HI  = 2'b10;
	localparam wmask_t MASK_ALL = 2'b11;

endpackage

`default_nettype wire

// File: design/cpu_core.sv
`default_nettype none
`timescale 1ns/100ps

module cpu_core (
	input  logic                          clk,
	input  logic                          resetn,
	output logic                          ibus_cyc,
	output logic                          ibus_stb,
	output logic [core_pkg::PC_W-1:0]     ibus_adr,
	input  logic [isa_pkg::instr_w-1:0]   ibus_dat,
	input  logic                          ibus_ack,
	output logic                          retire_valid,
	output logic [core_pkg::REG_AW-1:0]   retire_rd,
	output core_pkg::wmask_t              retire_mask,
	output logic [core_pkg::DATA_W-1:0]   retire_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic               id_valid;
	logic               id_ready;
	logic [instr_w-1:0] id_instr;
	logic [REG_AW-1:0]  rs1_addr;
	logic [REG_AW-1:0]  rs2_addr;
	logic [DATA_W-1:0]  rs1_data;
	logic [DATA_W-1:0]  rs2_data;
	logic               ex_valid;
	op_e                ex_op;
	logic [DATA_W-1:0]  ex_opnd1;
	logic [DATA_W-1:0]  ex_opnd2;
	logic [REG_AW-1:0]  ex_rd;
	logic               wb_valid;
	logic [REG_AW-1:0]  wb_rd;
	wmask_t             wb_mask;
	logic [DATA_W-1:0]  wb_data;

	fetch_stage i_fetch_stage (
		.clk      (clk),
		.resetn   (resetn),
		.ibus_cyc (ibus_cyc),
		.ibus_stb (ibus_stb),
		.ibus_adr (ibus_adr),
		.ibus_dat (ibus_dat),
		.ibus_ack (ibus_ack),
		.id_ready (id_ready),
		.id_valid (id_valid),
		.id_instr (id_instr)
	);

	decode_stage i_decode_stage (
		.clk      (clk),
		.resetn   (resetn),
		.id_valid (id_valid),
		.id_instr (id_instr),
		.id_ready (id_ready),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.ex_valid (ex_valid),
		.ex_op    (ex_op),
		.ex_opnd1 (ex_opnd1),
		.ex_opnd2 (ex_opnd2),
		.ex_rd    (ex_rd)
	);

	execute_stage i_execute_stage (
		.clk      (clk),
		.resetn   (resetn),
		.ex_valid (ex_valid),
		.ex_op    (ex_op),
		.ex_opnd1 (ex_opnd1),
		.ex_opnd2 (ex_opnd2),
		.ex_rd    (ex_rd),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_mask  (wb_mask),
		.wb_data  (wb_data)
	);

	reg_file i_reg_file (
		.clk      (clk),
		.resetn   (resetn),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_mask  (wb_mask),
		.wb_data  (wb_data)
	);

	// retirement is the register-file write itself
	assign retire_valid = wb_valid;
	assign retire_rd    = wb_rd;
	assign retire_mask  = wb_mask;
	assign retire_data  = wb_data;

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          id_valid,
	input  logic [isa_pkg::instr_w-1:0]   id_instr,
	output logic                          id_ready,
	output logic [core_pkg::REG_AW-1:0]   rs1_addr,
	output logic [core_pkg::REG_AW-1:0]   rs2_addr,
	input  logic [core_pkg::DATA_W-1:0]   rs1_data,
	input  logic [core_pkg::DATA_W-1:0]   rs2_data,
	input  logic                          wb_valid,
	input  logic [core_pkg::REG_AW-1:0]   wb_rd,
	output logic                          ex_valid,
	output isa_pkg::op_e                  ex_op,
	output logic [core_pkg::DATA_W-1:0]   ex_opnd1,
	output logic [core_pkg::DATA_W-1:0]   ex_opnd2,
	output logic [core_pkg::REG_AW-1:0]   ex_rd
);
	import isa_pkg::*;
	import core_pkg::*;

	instr_u            instr;
	logic              is_alu;
	logic              stall;
	logic [DATA_W-1:0] opnd2;

	assign instr    = id_instr;
	assign rs1_addr = instr.r.rd_rs1;
	assign rs2_addr = instr.r.rs2;
	assign id_ready = !stall;

	always_comb begin
		case (instr.r.itype)
			ITYPE_ALU: is_alu = 1'b1;
			ITYPE_NOP, ITYPE_MEM, ITYPE_AUDIO: is_alu = 1'b0;
		endcase
	end

	// second operand, register or zero-extended immediate
	always_comb begin
		if (!instr.r.imm_en)
			opnd2 = rs2_data;
		else if (instr.i.op == OP_MOVU)
			opnd2 = {instr.i.imm, {HALF_W{1'b0}}}; // lands in the upper half
		else
			opnd2 = {{HALF_W{1'b0}}, instr.i.imm};
	end

	hazard_unit i_hazard_unit (
		.id_instr  (instr),
		.id_valid  (id_valid),
		.ex_valid  (ex_valid),
		.ex_rd     (ex_rd),
		.ex_writes (1'b1), // every alu op writes rd_rs1
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.stall     (stall)
	);

	// ID/EX valid, a bubble on stall or a non-alu type
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= id_valid && is_alu && !stall;
		end
	end

	always_ff @(posedge clk) begin
		if (id_valid && !stall) begin
			ex_op    <= instr.r.op;
			ex_opnd1 <= rs1_data;
			ex_opnd2 <= opnd2;
			ex_rd    <= instr.r.rd_rs1;
		end
	end

	// a stalled instruction must not slip into EX
	a_stall_bubble: assert property (@(posedge clk) disable iff (!resetn)
		stall |=> !ex_valid);

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          ex_valid,
	input  isa_pkg::op_e                  ex_op,
	input  logic [core_pkg::DATA_W-1:0]   ex_opnd1,
	input  logic [core_pkg::DATA_W-1:0]   ex_opnd2,
	input  logic [core_pkg::REG_AW-1:0]   ex_rd,
	output logic                          wb_valid,
	output logic [core_pkg::REG_AW-1:0]   wb_rd,
	output core_pkg::wmask_t              wb_mask,
	output logic [core_pkg::DATA_W-1:0]   wb_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [DATA_W-1:0] result;
	wmask_t            mask;

	always_comb begin
		case (ex_op)
			OP_ADD:  result = ex_opnd1 + ex_opnd2;
			OP_SUB:  result = ex_opnd1 - ex_opnd2;
			OP_INC:  result = ex_opnd1 + DATA_W'(1);
			OP_MUL:  result = ex_opnd1 * ex_opnd2; // low word only
			OP_MOVL, OP_MOVU, OP_MOV: result = ex_opnd2;
			default: result = '0; // OP_ZERO
		endcase
	end

	// half-word moves touch one half only
	always_comb begin
		case (ex_op)
			OP_MOVL: mask = MASK_LO;
			OP_MOVU: mask = MASK_HI;
			default: mask = MASK_ALL;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd   <= ex_rd;
		wb_mask <= mask;
		wb_data <= result;
	end

	a_wb_mask: assert property (@(posedge clk) disable iff (!resetn)
		wb_valid |-> (wb_mask != '0));

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`default_nettype none
`timescale 1ns/100ps

module fetch_stage (
	input  logic                        clk,
	input  logic                        resetn,
	output logic                        ibus_cyc,
	output logic                        ibus_stb,
	output logic [core_pkg::PC_W-1:0]   ibus_adr,
	input  logic [isa_pkg::instr_w-1:0] ibus_dat,
	input  logic                        ibus_ack,
	input  logic                        id_ready,
	output logic                        id_valid,
	output logic [isa_pkg::instr_w-1:0] id_instr
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [PC_W-1:0]    pc;
	logic               head_valid;
	logic               skid_valid;
	logic [instr_w-1:0] head_instr;
	logic [instr_w-1:0] skid_instr;
	logic               head_valid_n;
	logic               skid_valid_n;
	logic [instr_w-1:0] head_instr_n;
	logic [instr_w-1:0] skid_instr_n;
	logic               pop;
	logic               ack_fire;
	logic               req_n;

	assign pop      = head_valid && id_ready;
	assign ack_fire = ibus_stb && ibus_ack;

	// buffer next state
	always_comb begin
		head_valid_n = head_valid;
		head_instr_n = head_instr;
		skid_valid_n = skid_valid;
		skid_instr_n = skid_instr;
		if (pop) begin
			head_valid_n = skid_valid; // skid slides into head
			head_instr_n = skid_instr;
			skid_valid_n = 1'b0;
		end
		if (ack_fire) begin
			if (!head_valid_n) begin
				head_valid_n = 1'b1;
				head_instr_n = ibus_dat;
			end else begin
				skid_valid_n = 1'b1; // head is held, park the word
				skid_instr_n = ibus_dat;
			end
		end
	end

	// keep the current cycle until ack, else open one while skid has room
	assign req_n = (ibus_stb && !ibus_ack) || !skid_valid_n;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			pc         <= '0;
			ibus_cyc   <= 1'b0;
			ibus_stb   <= 1'b0;
			head_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else begin
			if (ack_fire)
				pc <= pc + 1'b1;
			ibus_cyc   <= req_n;
			ibus_stb   <= req_n;
			head_valid <= head_valid_n;
			skid_valid <= skid_valid_n;
		end
	end

	always_ff @(posedge clk) begin
		head_instr <= head_instr_n;
		skid_instr <= skid_instr_n;
	end

	assign ibus_adr = pc;
	assign id_valid = head_valid;
	assign id_instr = head_instr;

	a_stb_cyc: assert property (@(posedge clk) disable iff (!resetn)
		ibus_stb |-> ibus_cyc);

	// a pending transfer keeps its strobe and address until the slave acks
	a_adr_hold: assert property (@(posedge clk) disable iff (!resetn)
		(ibus_stb && !ibus_ack) |=> (ibus_stb && $stable(ibus_adr)));

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
`default_nettype none
`timescale 1ns/100ps

module hazard_unit (
	input  isa_pkg::instr_u               id_instr,
	input  logic                          id_valid,
	input  logic                          ex_valid,
	input  logic [core_pkg::REG_AW-1:0]   ex_rd,
	input  logic                          ex_writes,
	input  logic                          wb_valid,
	input  logic [core_pkg::REG_AW-1:0]   wb_rd,
	output logic                          stall
);
	import isa_pkg::*;

	logic reads_rs2;
	logic hit_ex;
	logic hit_wb;

	// rd_rs1 is always a source, rs2 only for two-register ops
	assign reads_rs2 = !id_instr.r.imm_en &&
		!(id_instr.r.op inside {OP_INC, OP_MOVL, OP_MOVU});

	assign hit_ex = ex_valid && ex_writes &&
		((ex_rd == id_instr.r.rd_rs1) || (reads_rs2 && ex_rd == id_instr.r.rs2));

	assign hit_wb = wb_valid &&
		((wb_rd == id_instr.r.rd_rs1) || (reads_rs2 && wb_rd == id_instr.r.rs2));

	// no bypass, wait until the writer is in the register file
	assign stall = id_valid && (id_instr.r.itype == ITYPE_ALU) && (hit_ex || hit_wb);

endmodule

`default_nettype wire

// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int instr_w = 32;

	// instruction class, bits 30:29
	typedef enum logic [1:0] {
		ITYPE_NOP   = 2'b00,
		ITYPE_ALU   = 2'b01,
		ITYPE_MEM   = 2'b10, // no memory stage, runs as nop
		ITYPE_AUDIO = 2'b11  // no audio unit, runs as nop
	} itype_e;

	// operation, bits 28:26
	typedef enum logic [2:0] {
		OP_ZERO = 3'b000,
		OP_ADD  = 3'b001,
		OP_SUB  = 3'b010,
		OP_INC  = 3'b011,
		OP_MUL  = 3'b100,
		OP_MOVL = 3'b101,
		OP_MOVU = 3'b110,
		OP_MOV  = 3'b111
	} op_e;

	// register form, two source registers
	typedef struct packed {
		logic        imm_en;
		itype_e      itype;
		op_e         op;
		logic [1:0]  chan;    // audio channel, ignored
		logic [1:0]  rsvd;
		logic [2:0]  rd_rs1;
		logic [2:0]  rs2;
		logic [15:0] rsvd_lo;
	} instr_reg_s;

	// immediate form, 16-bit immediate in the low bits
	typedef struct packed {
		logic        imm_en;
		itype_e      itype;
		op_e         op;
		logic [1:0]  chan;
		logic [1:0]  rsvd;
		logic [2:0]  rd_rs1;
		logic [2:0]  ign;
		logic [15:0] imm;
	} instr_imm_s;

	typedef union packed {
		instr_reg_s r;
		instr_imm_s i;
	} instr_u;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none
`timescale 1ns/100ps

module reg_file (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic [core_pkg::REG_AW-1:0]   rs1_addr,
	input  logic [core_pkg::REG_AW-1:0]   rs2_addr,
	output logic [core_pkg::DATA_W-1:0]   rs1_data,
	output logic [core_pkg::DATA_W-1:0]   rs2_data,
	input  logic                          wb_valid,
	input  logic [core_pkg::REG_AW-1:0]   wb_rd,
	input  core_pkg::wmask_t              wb_mask,
	input  logic [core_pkg::DATA_W-1:0]   wb_data
);
	import core_pkg::*;

	logic [DATA_W-1:0] regs [REG_N];

	// combinational reads, new value visible the cycle after the write edge
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < REG_N; i++)
				regs[i] <= '0;
		end else if (wb_valid) begin
			if (wb_mask[0])
				regs[wb_rd][HALF_W-1:0] <= wb_data[HALF_W-1:0];
			if (wb_mask[1])
				regs[wb_rd][DATA_W-1:HALF_W] <= wb_data[DATA_W-1:HALF_W];
		end
	end

endmodule

`default_nettype wire

// File: flist.f
design/isa_pkg.sv
design/core_pkg.sv
design/fetch_stage.sv
design/hazard_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/reg_file.sv
design/cpu_core.sv
verif/tb_cpu_core.sv

// File: verif/tb_cpu_core.sv
`default_nettype none
`timescale 1ns/100ps

module tb_cpu_core;
	import isa_pkg::*;
	import core_pkg::*;

	localparam int CLK_PERIOD       = 8;
	localparam int RESET_CYCLES     = 8;
	localparam int NUM_INSTR        = 2000;
	localparam int CYCLES_PER_INSTR = 12; // worst case with waits and stalls
	localparam int DRAIN_CYCLES     = 20;

	logic               clk;
	logic               resetn;
	logic               ibus_cyc;
	logic               ibus_stb;
	logic [PC_W-1:0]    ibus_adr;
	logic [instr_w-1:0] ibus_dat;
	logic               ibus_ack;
	logic               retire_valid;
	logic [REG_AW-1:0]  retire_rd;
	wmask_t             retire_mask;
	logic [DATA_W-1:0]  retire_data;

	integer             seed;
	int                 errors;
	int                 issued;
	int                 writers_issued;
	int                 retired;
	logic               busy;      // slave holds a word for the current address
	int                 wait_left;
	logic [instr_w-1:0] pending_word;
	logic [PC_W-1:0]    next_adr;
	logic [DATA_W-1:0]  model_regs [REG_N];
	logic [instr_w-1:0] program_q [$]; // words in issue order

	cpu_core i_cpu_core (
		.clk          (clk),
		.resetn       (resetn),
		.ibus_cyc     (ibus_cyc),
		.ibus_stb     (ibus_stb),
		.ibus_adr     (ibus_adr),
		.ibus_dat     (ibus_dat),
		.ibus_ack     (ibus_ack),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_mask  (retire_mask),
		.retire_data  (retire_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic is_writer(input logic [instr_w-1:0] word);
		instr_u w;
		w = word;
		return w.r.itype == ITYPE_ALU;
	endfunction

	// mostly r0..r2 so that back-to-back dependencies are common
	task automatic pick_reg(output logic [REG_AW-1:0] r);
		if (($random(seed) & 3) != 0)
			r = REG_AW'({$random(seed)} % 3);
		else
			r = REG_AW'($random(seed));
	endtask

	task automatic make_instr(output logic [instr_w-1:0] word);
		instr_u            w;
		logic [REG_AW-1:0] r;
		w = $random(seed); // imm flag, op and ignored bits stay random
		if (({$random(seed)} % 5) == 0) begin
			case ({$random(seed)} % 3)
				0: w.r.itype = ITYPE_NOP;
				1: w.r.itype = ITYPE_MEM;
				default: w.r.itype = ITYPE_AUDIO;
			endcase
		end else begin
			w.r.itype = ITYPE_ALU;
		end
		if (w.r.op inside {OP_MOVL, OP_MOVU})
			w.r.imm_en = 1'b1; // half moves take the immediate
		pick_reg(r);
		w.r.rd_rs1 = r;
		if (!w.r.imm_en) begin
			pick_reg(r);
			w.r.rs2 = r;
		end
		word = w;
	endtask

	// reference model, one instruction at a time in program order
	task automatic predict(input logic [instr_w-1:0] word, output logic [REG_AW-1:0] rd,
		output wmask_t mask, output logic [DATA_W-1:0] data);
		instr_u            w;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		w = word;
		rd = w.r.rd_rs1;
		a = model_regs[rd];
		if (!w.r.imm_en)
			b = model_regs[w.r.rs2];
		else if (w.i.op == OP_MOVU)
			b = {w.i.imm, 16'h0000};
		else
			b = {16'h0000, w.i.imm};
		mask = 2'b11;
		case (w.r.op)
			OP_ZERO: data = '0;
			OP_ADD:  data = a + b;
			OP_SUB:  data = a - b;
			OP_INC:  data = a + 32'd1;
			OP_MUL:  data = a * b;
			OP_MOVL: begin
				data = b;
				mask = 2'b01;
			end
			OP_MOVU: begin
				data = b;
				mask = 2'b10;
			end
			default: data = b; // OP_MOV
		endcase
		if (mask[0])
			model_regs[rd][15:0] = data[15:0];
		if (mask[1])
			model_regs[rd][31:16] = data[31:16];
	endtask

	task automatic check_retire();
		logic [instr_w-1:0] word;
		logic [REG_AW-1:0]  rd;
		wmask_t             mask;
		logic [DATA_W-1:0]  data;
		logic               found;
		found = 1'b0;
		while (!found && program_q.size() > 0) begin
			word = program_q.pop_front();
			found = is_writer(word); // nop, memory and audio words retire nothing
		end
		retired++;
		assert (found) else begin
			errors++;
			$display("retirement at %0t ns with no writing instruction left to match", $time);
		end
		if (found) begin
			predict(word, rd, mask, data);
			assert (retire_rd == rd) else begin
				errors++;
				$display("Fail at %0t ns retire_rd expected %0d got %0d", $time, rd, retire_rd);
			end
			assert (retire_mask == mask) else begin
				errors++;
				$display("Fail at %0t ns retire_mask expected %b got %b",
					$time, mask, retire_mask);
			end
			assert (retire_data == data) else begin
				errors++;
				$display("Fail at %0t ns retire_data expected %h got %h",
					$time, data, retire_data);
			end
		end
	endtask

	// wishbone slave, 0 to 3 wait cycles per new address
	always begin
		@(posedge clk);
		#1;
		ibus_ack = 1'b0;
		if (resetn && ibus_stb && issued < NUM_INSTR) begin
			assert (ibus_cyc) else begin
				errors++;
				$display("Fail at %0t ns ibus_cyc expected 1 got %b", $time, ibus_cyc);
			end
			assert (ibus_adr == next_adr) else begin
				errors++;
				$display("Fail at %0t ns ibus_adr expected %h got %h", $time, next_adr, ibus_adr);
			end
			if (!busy) begin
				busy = 1'b1;
				wait_left = $random(seed) & 3;
				make_instr(pending_word);
			end
			if (wait_left == 0) begin
				ibus_ack = 1'b1;
				ibus_dat = pending_word;
				busy = 1'b0;
				program_q.push_back(pending_word);
				issued++;
				next_adr++;
				if (is_writer(pending_word))
					writers_issued++;
			end else begin
				wait_left--;
			end
		end
	end

	always begin
		@(posedge clk);
		#1;
		if (resetn && retire_valid)
			check_retire();
	end

	initial begin
		seed = 75;
		clk = 1'b0;
		resetn = 1'b0;
		ibus_dat = '0;
		ibus_ack = 1'b0;
		errors = 0;
		issued = 0;
		writers_issued = 0;
		retired = 0;
		busy = 1'b0;
		wait_left = 0;
		next_adr = '0;
		for (int i = 0; i < REG_N; i++)
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		assert (!ibus_cyc) else begin
			errors++;
			$display("Fail at %0t ns ibus_cyc expected 0 got %b", $time, ibus_cyc);
		end
		assert (!ibus_stb) else begin
			errors++;
			$display("Fail at %0t ns ibus_stb expected 0 got %b", $time, ibus_stb);
		end
		assert (!retire_valid) else begin
			errors++;
			$display("Fail at %0t ns retire_valid expected 0 got %b", $time, retire_valid);
		end
		resetn = 1'b1;
		wait (issued == NUM_INSTR);
		while (retired < writers_issued)
			@(posedge clk);
		repeat (DRAIN_CYCLES) @(posedge clk); // catch stray retirements
		#2;
		assert (retired == writers_issued) else begin
			errors++;
			$display("Fail at %0t ns retire count expected %0d got %0d",
				$time, writers_issued, retired);
		end
		$display("errors %0d, issued %0d, writers %0d, retired %0d",
			errors, issued, writers_issued, retired);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// watchdog
	initial begin
		#((RESET_CYCLES + NUM_INSTR * CYCLES_PER_INSTR) * CLK_PERIOD);
		$display("watchdog expired, the core stopped fetching or retiring");
		$display("errors %0d, issued %0d, writers %0d, retired %0d",
			errors, issued, writers_issued, retired);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
